// File: sources.f
source/trialign_pkg.sv
source/seq_fetch.sv
source/plane_store.sv
source/cell_score.sv
source/trialign_top.sv
dv/tb_trialign.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_trialign
FILELIST  ?= sources.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: dv/tb_trialign.sv
`timescale 1ns/1ns

module tb_trialign;
  import trialign_pkg::*;

  logic                         CLK;
  logic                         rst;
  logic                         start_i;
  logic [LEN_A_BITS-1:0]        len_a_i;
  logic [LEN_BC_BITS-1:0]       len_b_i;
  logic [LEN_BC_BITS-1:0]       len_c_i;
  logic [SYM_BITS-1:0]          a_sym_i;
  logic [SYM_BITS-1:0]          b_sym_i;
  logic [SYM_BITS-1:0]          c_sym_i;
  logic                         score_ready_i;
  logic [A_ADDR_BITS-1:0]       a_addr_o;
  logic [BC_ADDR_BITS-1:0]      b_addr_o;
  logic [BC_ADDR_BITS-1:0]      c_addr_o;
  logic                         busy_o;
  logic signed [SCORE_BITS-1:0] score_o;
  logic                         score_valid_o;

  // symbol memories read asynchronously
  logic [SYM_BITS-1:0] a_mem [LEN_A_MAX];
  logic [SYM_BITS-1:0] b_mem [LEN_BC_MAX];
  logic [SYM_BITS-1:0] c_mem [LEN_BC_MAX];

  int    seed = 57207;
  int    job_timeout = 30000;
  int    step_timeout = 200;
  int    exp_q [$];
  string name_q [$];

  assign a_sym_i = a_mem[a_addr_o];
  assign b_sym_i = b_mem[b_addr_o];
  assign c_sym_i = c_mem[c_addr_o];

  trialign_top UUT (
    .CLK           (CLK),
    .rst           (rst),
    .start_i       (start_i),
    .len_a_i       (len_a_i),
    .len_b_i       (len_b_i),
    .len_c_i       (len_c_i),
    .a_sym_i       (a_sym_i),
    .b_sym_i       (b_sym_i),
    .c_sym_i       (c_sym_i),
    .score_ready_i (score_ready_i),
    .a_addr_o      (a_addr_o),
    .b_addr_o      (b_addr_o),
    .c_addr_o      (c_addr_o),
    .busy_o        (busy_o),
    .score_o       (score_o),
    .score_valid_o (score_valid_o)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic int rand_range(int lo, int hi);
    int v;
    v = $random(seed) & 32'h7fff_ffff;
    return lo + v % (hi - lo + 1);
  endfunction

  // pair score for both present, one gap or both gaps
  function automatic int pair_value(int hx, int hy, int x, int y);
    if (hx != 0 && hy != 0) begin
      return (x == y) ? MATCH_SCORE : MISMATCH_SCORE;
    end else if (hx != 0 || hy != 0) begin
      return GAP_SCORE;
    end
    return 0;
  endfunction

  // full 3-D sum-of-pairs DP over the current memories
  function automatic int ref_score(int la, int lb, int lc);
    int dp [LEN_A_MAX+1][LEN_BC_MAX+1][LEN_BC_MAX+1];
    int i, j, k, m;
    int di, dj, dk;
    int sa, sb, sc;
    int cost, prev, best;
    for (i = 0; i <= la; i++) begin
      for (j = 0; j <= lb; j++) begin
        for (k = 0; k <= lc; k++) begin
          sa = (i > 0) ? int'(a_mem[A_ADDR_BITS'(i - 1)]) : 0;
          sb = (j > 0) ? int'(b_mem[BC_ADDR_BITS'(j - 1)]) : 0;
          sc = (k > 0) ? int'(c_mem[BC_ADDR_BITS'(k - 1)]) : 0;
          best = (i == 0 && j == 0 && k == 0) ? 0 : -100000;
          // each nonempty subset of sequences advances by one
          for (m = 1; m < 8; m++) begin
            di = m % 2;
            dj = (m / 2) % 2;
            dk = m / 4;
            if (i >= di && j >= dj && k >= dk) begin
              cost = pair_value(di, dj, sa, sb) + pair_value(di, dk, sa, sc) +
                     pair_value(dj, dk, sb, sc);
              prev = dp[LEN_A_BITS'(i - di)][LEN_BC_BITS'(j - dj)][LEN_BC_BITS'(k - dk)];
              if (prev + cost > best) begin
                best = prev + cost;
              end
            end
          end
          dp[LEN_A_BITS'(i)][LEN_BC_BITS'(j)][LEN_BC_BITS'(k)] = best;
        end
      end
    end
    return dp[LEN_A_BITS'(la)][LEN_BC_BITS'(lb)][LEN_BC_BITS'(lc)];
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, int expected, int actual);
    if (expected != actual) begin
      $display("ERROR %s expected %0d actual %0d", name, expected, actual);
      abort_run("a compared value was wrong");
    end
  endtask

  task automatic drive_slot();
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_busy(logic level, string what);
    int n;
    for (n = 0; n < step_timeout; n++) begin
      @(negedge CLK);
      if (busy_o === level) begin
        return;
      end
    end
    abort_run({"timed out waiting for busy during ", what});
  endtask

  task automatic wait_score_valid(string what);
    int n;
    for (n = 0; n < job_timeout; n++) begin
      @(negedge CLK);
      if (score_valid_o === 1'b1) begin
        return;
      end
    end
    abort_run({"timed out waiting for a score during ", what});
  endtask

  // queue is emptied by the compare process at the falling edge
  task automatic wait_all_scored(string what);
    int n;
    for (n = 0; n < job_timeout; n++) begin
      @(posedge CLK);
      if (exp_q.size() == 0) begin
        return;
      end
    end
    abort_run({"timed out waiting for all scores during ", what});
  endtask

  task automatic fill_random();
    int n;
    for (n = 0; n < LEN_A_MAX; n++) begin
      a_mem[A_ADDR_BITS'(n)] = SYM_BITS'(rand_range(0, 3));
    end
    for (n = 0; n < LEN_BC_MAX; n++) begin
      b_mem[BC_ADDR_BITS'(n)] = SYM_BITS'(rand_range(0, 3));
      c_mem[BC_ADDR_BITS'(n)] = SYM_BITS'(rand_range(0, 3));
    end
  endtask

  // expected score is queued before the start pulse
  task automatic launch_job(string name, int la, int lb, int lc);
    exp_q.push_back(ref_score(la, lb, lc));
    name_q.push_back(name);
    wait_busy(1'b0, name);
    drive_slot();
    len_a_i = LEN_A_BITS'(la);
    len_b_i = LEN_BC_BITS'(lb);
    len_c_i = LEN_BC_BITS'(lc);
    start_i = 1'b1;
    drive_slot();
    start_i = 1'b0;
  endtask

  task automatic run_identical(int len);
    int n;
    drive_slot();
    fill_random();
    for (n = 0; n < len; n++) begin
      b_mem[BC_ADDR_BITS'(n)] = a_mem[A_ADDR_BITS'(n)];
      c_mem[BC_ADDR_BITS'(n)] = a_mem[A_ADDR_BITS'(n)];
    end
    check_value("identical reference", 3 * MATCH_SCORE * len, ref_score(len, len, len));
    launch_job("identical", len, len, len);
    wait_all_scored("identical");
  endtask

  // compare at the falling edge before the transfer edge
  always @(negedge CLK) begin
    if (!rst && score_valid_o && score_ready_i) begin
      if (exp_q.size() == 0) begin
        abort_run("a score arrived while no job was pending");
      end else begin
        check_value(name_q.pop_front(), exp_q.pop_front(), int'(score_o));
      end
    end
  end

  initial begin : stimulus
    int n;
    int la;
    int lb;
    int lc;
    int hold;
    rst = 1'b1;
    start_i = 1'b0;
    len_a_i = '0;
    len_b_i = '0;
    len_c_i = '0;
    score_ready_i = 1'b1;
    for (n = 0; n < LEN_A_MAX; n++) begin
      a_mem[A_ADDR_BITS'(n)] = SYM_BITS'(n ^ (n >> 4));
    end
    for (n = 0; n < LEN_BC_MAX; n++) begin
      b_mem[BC_ADDR_BITS'(n)] = SYM_BITS'(n * 3 + 1);
      c_mem[BC_ADDR_BITS'(n)] = SYM_BITS'(~n);
    end
    repeat (16) @(posedge CLK);
    #2;
    rst = 1'b0;
    @(negedge CLK);
    check_value("reset busy", 0, int'(busy_o));
    check_value("reset score valid", 0, int'(score_valid_o));

    run_identical(8);
    run_identical(3);

    // single column with all equal then all different symbols
    drive_slot();
    a_mem[0] = 4'd5;
    b_mem[0] = 4'd5;
    c_mem[0] = 4'd5;
    check_value("minimal equal reference", 6, ref_score(1, 1, 1));
    launch_job("minimal equal", 1, 1, 1);
    wait_all_scored("minimal equal");
    drive_slot();
    a_mem[0] = 4'd1;
    b_mem[0] = 4'd2;
    c_mem[0] = 4'd3;
    check_value("minimal unequal reference", -3, ref_score(1, 1, 1));
    launch_job("minimal unequal", 1, 1, 1);
    wait_all_scored("minimal unequal");

    // first random job uses the largest space
    for (n = 0; n < 20; n++) begin
      drive_slot();
      fill_random();
      la = (n == 0) ? LEN_A_MAX : rand_range(1, LEN_A_MAX);
      lb = (n == 0) ? LEN_BC_MAX : rand_range(1, LEN_BC_MAX);
      lc = (n == 0) ? LEN_BC_MAX : rand_range(1, LEN_BC_MAX);
      launch_job($sformatf("random job %0d", n), la, lb, lc);
      wait_all_scored("random jobs");
    end

    // back-pressure with a second job started behind the pending score
    drive_slot();
    score_ready_i = 1'b0;
    fill_random();
    launch_job("backpressure first", rand_range(1, 12), rand_range(1, 8), rand_range(1, 8));
    wait_score_valid("backpressure");
    drive_slot();
    fill_random();
    launch_job("backpressure second", rand_range(1, 12), rand_range(1, 8), rand_range(1, 8));
    hold = rand_range(3, 30);
    for (n = 0; n < hold; n++) begin
      @(negedge CLK);
      check_value("backpressure valid held", 1, int'(score_valid_o));
      check_value("backpressure score held", exp_q[0], int'(score_o));
    end
    drive_slot();
    score_ready_i = 1'b1;
    wait_all_scored("backpressure");

    // start pulse with other lengths while busy
    drive_slot();
    fill_random();
    launch_job("busy start ignored", 20, 6, 5);
    wait_busy(1'b1, "busy start");
    repeat (3) drive_slot();
    len_a_i = LEN_A_BITS'(1);
    len_b_i = LEN_BC_BITS'(1);
    len_c_i = LEN_BC_BITS'(1);
    start_i = 1'b1;
    @(negedge CLK);
    check_value("busy during extra start", 1, int'(busy_o));
    drive_slot();
    start_i = 1'b0;
    wait_all_scored("busy start");
    // window for a stray score from the ignored start
    repeat (60) @(posedge CLK);
    @(negedge CLK);
    check_value("idle after job", 0, int'(busy_o));

    $display("** PASS **");
    $finish;
  end

endmodule

// File: source/trialign_top.sv
`timescale 1ns/1ns

module trialign_top (
  input  logic                                       CLK,
  input  logic                                       rst,
  input  logic                                       start_i,
  input  logic [trialign_pkg::LEN_A_BITS-1:0]         len_a_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        len_b_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        len_c_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]           a_sym_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]           b_sym_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]           c_sym_i,
  input  logic                                       score_ready_i,
  output logic [trialign_pkg::A_ADDR_BITS-1:0]        a_addr_o,
  output logic [trialign_pkg::BC_ADDR_BITS-1:0]       b_addr_o,
  output logic [trialign_pkg::BC_ADDR_BITS-1:0]       c_addr_o,
  output logic                                       busy_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  score_o,
  output logic                                       score_valid_o
);
  import trialign_pkg::*;

  // cell stream
  logic                   cell_valid;
  logic                   cell_ready;
  logic [SYM_BITS-1:0]    cell_sym_a;
  logic [SYM_BITS-1:0]    cell_sym_b;
  logic [SYM_BITS-1:0]    cell_sym_c;
  logic [LEN_BC_BITS-1:0] cell_j;
  logic [LEN_BC_BITS-1:0] cell_k;
  logic                   cell_first_plane;
  logic                   cell_last;

  // plane buffer
  logic                         wr_en;
  logic                         wr_plane;
  logic [LEN_BC_BITS-1:0]       wr_j;
  logic [LEN_BC_BITS-1:0]       wr_k;
  logic signed [SCORE_BITS-1:0] wr_score;
  logic                         rd_plane;
  logic [LEN_BC_BITS-1:0]       rd_j;
  logic [LEN_BC_BITS-1:0]       rd_k;
  logic signed [SCORE_BITS-1:0] prev_jk;
  logic signed [SCORE_BITS-1:0] prev_j1k;
  logic signed [SCORE_BITS-1:0] prev_jk1;
  logic signed [SCORE_BITS-1:0] prev_j1k1;
  logic signed [SCORE_BITS-1:0] cur_j1k;
  logic signed [SCORE_BITS-1:0] cur_jk1;
  logic signed [SCORE_BITS-1:0] cur_j1k1;

  seq_fetch u_fetch (
    .CLK                (CLK),
    .rst                (rst),
    .start_i            (start_i),
    .len_a_i            (len_a_i),
    .len_b_i            (len_b_i),
    .len_c_i            (len_c_i),
    .a_sym_i            (a_sym_i),
    .b_sym_i            (b_sym_i),
    .c_sym_i            (c_sym_i),
    .cell_ready_i       (cell_ready),
    .a_addr_o           (a_addr_o),
    .b_addr_o           (b_addr_o),
    .c_addr_o           (c_addr_o),
    .busy_o             (busy_o),
    .cell_valid_o       (cell_valid),
    .cell_sym_a_o       (cell_sym_a),
    .cell_sym_b_o       (cell_sym_b),
    .cell_sym_c_o       (cell_sym_c),
    .cell_j_o           (cell_j),
    .cell_k_o           (cell_k),
    .cell_first_plane_o (cell_first_plane),
    .cell_last_o        (cell_last)
  );

  plane_store u_store (
    .CLK         (CLK),
    .rst         (rst),
    .wr_en_i     (wr_en),
    .wr_plane_i  (wr_plane),
    .wr_j_i      (wr_j),
    .wr_k_i      (wr_k),
    .wr_score_i  (wr_score),
    .rd_plane_i  (rd_plane),
    .rd_j_i      (rd_j),
    .rd_k_i      (rd_k),
    .prev_jk_o   (prev_jk),
    .prev_j1k_o  (prev_j1k),
    .prev_jk1_o  (prev_jk1),
    .prev_j1k1_o (prev_j1k1),
    .cur_j1k_o   (cur_j1k),
    .cur_jk1_o   (cur_jk1),
    .cur_j1k1_o  (cur_j1k1)
  );

  cell_score u_score (
    .CLK                (CLK),
    .rst                (rst),
    .cell_valid_i       (cell_valid),
    .cell_sym_a_i       (cell_sym_a),
    .cell_sym_b_i       (cell_sym_b),
    .cell_sym_c_i       (cell_sym_c),
    .cell_j_i           (cell_j),
    .cell_k_i           (cell_k),
    .cell_first_plane_i (cell_first_plane),
    .cell_last_i        (cell_last),
    .prev_jk_i          (prev_jk),
    .prev_j1k_i         (prev_j1k),
    .prev_jk1_i         (prev_jk1),
    .prev_j1k1_i        (prev_j1k1),
    .cur_j1k_i          (cur_j1k),
    .cur_jk1_i          (cur_jk1),
    .cur_j1k1_i         (cur_j1k1),
    .score_ready_i      (score_ready_i),
    .cell_ready_o       (cell_ready),
    .wr_en_o            (wr_en),
    .wr_plane_o         (wr_plane),
    .wr_j_o             (wr_j),
    .wr_k_o             (wr_k),
    .wr_score_o         (wr_score),
    .rd_plane_o         (rd_plane),
    .rd_j_o             (rd_j),
    .rd_k_o             (rd_k),
    .score_o            (score_o),
    .score_valid_o      (score_valid_o)
  );

endmodule

// File: source/cell_score.sv
`timescale 1ns/1ns

module cell_score (
  input  logic                                       CLK,
  input  logic                                       rst,
  input  logic                                       cell_valid_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]           cell_sym_a_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]           cell_sym_b_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]           cell_sym_c_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        cell_j_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        cell_k_i,
  input  logic                                       cell_first_plane_i,
  input  logic                                       cell_last_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_jk_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_j1k_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_jk1_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_j1k1_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  cur_j1k_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  cur_jk1_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  cur_j1k1_i,
  input  logic                                       score_ready_i,
  output logic                                       cell_ready_o,
  output logic                                       wr_en_o,
  output logic                                       wr_plane_o,
  output logic [trialign_pkg::LEN_BC_BITS-1:0]        wr_j_o,
  output logic [trialign_pkg::LEN_BC_BITS-1:0]        wr_k_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  wr_score_o,
  output logic                                       rd_plane_o,
  output logic [trialign_pkg::LEN_BC_BITS-1:0]        rd_j_o,
  output logic [trialign_pkg::LEN_BC_BITS-1:0]        rd_k_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  score_o,
  output logic                                       score_valid_o
);
  import trialign_pkg::*;

  logic                         plane_q;
  logic                         wr_last_q;
  logic                         xfer;
  logic                         has_i;
  logic                         has_j;
  logic                         has_k;
  logic                         fwd_jk1;
  logic signed [SCORE_BITS-1:0] jk1_val;
  logic signed [SCORE_BITS-1:0] gap2;
  logic signed [SCORE_BITS-1:0] p_ab;
  logic signed [SCORE_BITS-1:0] p_ac;
  logic signed [SCORE_BITS-1:0] p_bc;
  logic signed [SCORE_BITS-1:0] cand [NUM_MOVES];
  logic [NUM_MOVES-1:0]         cand_ok;
  logic signed [SCORE_BITS-1:0] best;

  function automatic logic signed [SCORE_BITS-1:0] pair_cost(input logic [SYM_BITS-1:0] x,
                                                             input logic [SYM_BITS-1:0] y);
    pair_cost = (x == y) ? SCORE_BITS'(MATCH_SCORE) : SCORE_BITS'(MISMATCH_SCORE);
  endfunction

  assign cell_ready_o = !score_valid_o;
  assign xfer         = cell_valid_i && cell_ready_o;

  assign has_i = !cell_first_plane_i;
  assign has_j = (cell_j_i != '0);
  assign has_k = (cell_k_i != '0);

  // parity restarts with each job and flips at each plane origin
  assign rd_plane_o = (has_j || has_k) ? plane_q : (has_i ? ~plane_q : 1'b0);
  assign rd_j_o     = cell_j_i;
  assign rd_k_o     = cell_k_i;

  // (j,k-1) is usually still in the write stage
  assign fwd_jk1 = wr_en_o && (wr_plane_o == rd_plane_o) && (wr_j_o == cell_j_i) &&
                   (wr_k_o + 1'b1 == cell_k_i);
  assign jk1_val = fwd_jk1 ? wr_score_o : cur_jk1_i;

  assign gap2 = SCORE_BITS'(2 * GAP_SCORE);
  assign p_ab = pair_cost(cell_sym_a_i, cell_sym_b_i);
  assign p_ac = pair_cost(cell_sym_a_i, cell_sym_c_i);
  assign p_bc = pair_cost(cell_sym_b_i, cell_sym_c_i);

  // one candidate per move, masked at the borders
  assign cand[0] = prev_j1k1_i + p_ab + p_ac + p_bc;
  assign cand[1] = prev_j1k_i + p_ab + gap2;
  assign cand[2] = prev_jk1_i + p_ac + gap2;
  assign cand[3] = cur_j1k1_i + p_bc + gap2;
  assign cand[4] = prev_jk_i + gap2;
  assign cand[5] = cur_j1k_i + gap2;
  assign cand[6] = jk1_val + gap2;
  assign cand_ok = {has_k, has_j, has_i, has_j && has_k, has_i && has_k,
                    has_i && has_j, has_i && has_j && has_k};

  always_comb begin
    best = SCORE_BITS'(SCORE_FLOOR);
    for (int n = 0; n < NUM_MOVES; n++) begin
      if (cand_ok[n] && (cand[n] > best)) begin
        best = cand[n];
      end
    end
    // origin cell
    if (cand_ok == '0) begin
      best = '0;
    end
  end

  always_ff @(posedge CLK or posedge rst) begin
    if (rst) begin
      plane_q       <= 1'b0;
      wr_en_o       <= 1'b0;
      score_valid_o <= 1'b0;
    end else begin
      wr_en_o <= xfer;
      if (xfer) begin
        plane_q <= rd_plane_o;
      end
      if (wr_en_o && wr_last_q) begin
        score_valid_o <= 1'b1;
      end else if (score_ready_i) begin
        score_valid_o <= 1'b0;
      end
    end
  end

  // write stage and result
  always_ff @(posedge CLK) begin
    if (xfer) begin
      wr_plane_o <= rd_plane_o;
      wr_j_o     <= cell_j_i;
      wr_k_o     <= cell_k_i;
      wr_score_o <= best;
      wr_last_q  <= cell_last_i;
    end
    if (wr_en_o && wr_last_q) begin
      score_o <= wr_score_o;
    end
  end

  a_score_hold: assert property (@(posedge CLK) disable iff (rst)
    score_valid_o && !score_ready_i |=> score_valid_o && $stable(score_o));

  a_no_wr_pending: assert property (@(posedge CLK) disable iff (rst)
    !(wr_en_o && score_valid_o));

endmodule

// File: source/plane_store.sv
`timescale 1ns/1ns

module plane_store (
  input  logic                                       CLK,
  input  logic                                       rst,
  input  logic                                       wr_en_i,
  input  logic                                       wr_plane_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        wr_j_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        wr_k_i,
  input  logic signed [trialign_pkg::SCORE_BITS-1:0]  wr_score_i,
  input  logic                                       rd_plane_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        rd_j_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]        rd_k_i,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_jk_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_j1k_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_jk1_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  prev_j1k1_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  cur_j1k_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  cur_jk1_o,
  output logic signed [trialign_pkg::SCORE_BITS-1:0]  cur_j1k1_o
);
  import trialign_pkg::*;

  // two ping-pong planes indexed [plane][j][k]
  logic signed [SCORE_BITS-1:0] mem [2][LEN_BC_MAX+1][LEN_BC_MAX+1];
  logic                         other;
  logic [LEN_BC_BITS-1:0]       jm;
  logic [LEN_BC_BITS-1:0]       km;

  // index 0 wraps to the top row, that value is never used
  function automatic logic [LEN_BC_BITS-1:0] wrap_dec(input logic [LEN_BC_BITS-1:0] v);
    wrap_dec = (v == '0) ? LEN_BC_BITS'(LEN_BC_MAX) : v - 1'b1;
  endfunction

  assign other = ~rd_plane_i;
  assign jm    = wrap_dec(rd_j_i);
  assign km    = wrap_dec(rd_k_i);

  assign prev_jk_o   = mem[other][rd_j_i][rd_k_i];
  assign prev_j1k_o  = mem[other][jm][rd_k_i];
  assign prev_jk1_o  = mem[other][rd_j_i][km];
  assign prev_j1k1_o = mem[other][jm][km];
  assign cur_j1k_o   = mem[rd_plane_i][jm][rd_k_i];
  assign cur_jk1_o   = mem[rd_plane_i][rd_j_i][km];
  assign cur_j1k1_o  = mem[rd_plane_i][jm][km];

  always_ff @(posedge CLK) begin
    if (wr_en_i) begin
      mem[wr_plane_i][wr_j_i][wr_k_i] <= wr_score_i;
    end
  end

  a_wr_range: assert property (@(posedge CLK) disable iff (rst)
    wr_en_i |-> (wr_j_i <= LEN_BC_BITS'(LEN_BC_MAX)) && (wr_k_i <= LEN_BC_BITS'(LEN_BC_MAX)));

endmodule

// File: source/seq_fetch.sv
`timescale 1ns/1ns

module seq_fetch (
  input  logic                                 CLK,
  input  logic                                 rst,
  input  logic                                 start_i,
  input  logic [trialign_pkg::LEN_A_BITS-1:0]   len_a_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]  len_b_i,
  input  logic [trialign_pkg::LEN_BC_BITS-1:0]  len_c_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]     a_sym_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]     b_sym_i,
  input  logic [trialign_pkg::SYM_BITS-1:0]     c_sym_i,
  input  logic                                 cell_ready_i,
  output logic [trialign_pkg::A_ADDR_BITS-1:0]  a_addr_o,
  output logic [trialign_pkg::BC_ADDR_BITS-1:0] b_addr_o,
  output logic [trialign_pkg::BC_ADDR_BITS-1:0] c_addr_o,
  output logic                                 busy_o,
  output logic                                 cell_valid_o,
  output logic [trialign_pkg::SYM_BITS-1:0]     cell_sym_a_o,
  output logic [trialign_pkg::SYM_BITS-1:0]     cell_sym_b_o,
  output logic [trialign_pkg::SYM_BITS-1:0]     cell_sym_c_o,
  output logic [trialign_pkg::LEN_BC_BITS-1:0]  cell_j_o,
  output logic [trialign_pkg::LEN_BC_BITS-1:0]  cell_k_o,
  output logic                                 cell_first_plane_o,
  output logic                                 cell_last_o
);
  import trialign_pkg::*;

  logic [FSM_BITS-1:0]    state;
  logic [LEN_A_BITS-1:0]  len_a_q;
  logic [LEN_BC_BITS-1:0] len_b_q;
  logic [LEN_BC_BITS-1:0] len_c_q;
  logic [LEN_BC_BITS-1:0] ld_cnt;
  logic [LEN_BC_BITS-1:0] max_bc;
  logic [LEN_A_BITS-1:0]  i_q;
  logic [LEN_BC_BITS-1:0] j_q;
  logic [LEN_BC_BITS-1:0] k_q;
  logic [SYM_BITS-1:0]    a_sym_q;
  logic [SYM_BITS-1:0]    b_regs [LEN_BC_MAX];
  logic [SYM_BITS-1:0]    c_regs [LEN_BC_MAX];
  logic                   tail_q;
  logic                   start_ok;
  logic                   xfer;
  logic                   plane_start;

  // one extra busy cycle while the scorer retires the corner cell
  assign busy_o   = (state != ST_IDLE) || tail_q;
  assign start_ok = start_i && !busy_o;
  assign max_bc   = (len_b_q > len_c_q) ? len_b_q : len_c_q;

  assign cell_valid_o = (state == ST_WALK);
  assign xfer         = cell_valid_o && cell_ready_i;
  assign plane_start  = (j_q == '0) && (k_q == '0);

  assign b_addr_o = ld_cnt[BC_ADDR_BITS-1:0];
  assign c_addr_o = ld_cnt[BC_ADDR_BITS-1:0];
  assign a_addr_o = (i_q != '0) ? A_ADDR_BITS'(i_q - 1'b1) : '0;

  // A symbol comes straight from memory on the first cell of a plane
  assign cell_sym_a_o       = plane_start ? a_sym_i : a_sym_q;
  assign cell_sym_b_o       = b_regs[BC_ADDR_BITS'(j_q - 1'b1)];
  assign cell_sym_c_o       = c_regs[BC_ADDR_BITS'(k_q - 1'b1)];
  assign cell_j_o           = j_q;
  assign cell_k_o           = k_q;
  assign cell_first_plane_o = (i_q == '0);
  assign cell_last_o        = (i_q == len_a_q) && (j_q == len_b_q) && (k_q == len_c_q);

  always_ff @(posedge CLK or posedge rst) begin
    if (rst) begin
      state  <= ST_IDLE;
      ld_cnt <= '0;
      i_q    <= '0;
      j_q    <= '0;
      k_q    <= '0;
      tail_q <= 1'b0;
    end else begin
      tail_q <= xfer && cell_last_o;
      case (state)
        ST_IDLE: begin
          if (start_ok) begin
            state  <= ST_LOAD;
            ld_cnt <= '0;
          end
        end
        ST_LOAD: begin
          if (ld_cnt == max_bc - 1'b1) begin
            state <= ST_WALK;
            i_q   <= '0;
            j_q   <= '0;
            k_q   <= '0;
          end else begin
            ld_cnt <= ld_cnt + 1'b1;
          end
        end
        ST_WALK: begin
          // k innermost, then j, then i
          if (xfer) begin
            if (k_q != len_c_q) begin
              k_q <= k_q + 1'b1;
            end else begin
              k_q <= '0;
              if (j_q != len_b_q) begin
                j_q <= j_q + 1'b1;
              end else begin
                j_q <= '0;
                if (i_q != len_a_q) begin
                  i_q <= i_q + 1'b1;
                end else begin
                  state <= ST_IDLE;
                end
              end
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // lengths and symbols
  always_ff @(posedge CLK) begin
    if (start_ok) begin
      len_a_q <= len_a_i;
      len_b_q <= len_b_i;
      len_c_q <= len_c_i;
    end
    if (state == ST_LOAD) begin
      b_regs[ld_cnt[BC_ADDR_BITS-1:0]] <= b_sym_i;
      c_regs[ld_cnt[BC_ADDR_BITS-1:0]] <= c_sym_i;
    end
    if (xfer && plane_start) begin
      a_sym_q <= a_sym_i;
    end
  end

  a_cell_hold: assert property (@(posedge CLK) disable iff (rst)
    cell_valid_o && !cell_ready_i |=> cell_valid_o && $stable(cell_j_o) &&
      $stable(cell_k_o) && $stable(cell_sym_a_o) && $stable(cell_sym_b_o) &&
      $stable(cell_sym_c_o) && $stable(cell_first_plane_o) && $stable(cell_last_o));

endmodule

// File: source/trialign_pkg.sv
package trialign_pkg;

  // sequence limits
  localparam int LEN_A_MAX  = 64;
  localparam int LEN_BC_MAX = 8;

  // widths
  localparam int SYM_BITS     = 4;
  localparam int SCORE_BITS   = 12;
  localparam int A_ADDR_BITS  = 6;
  localparam int BC_ADDR_BITS = 3;
  // wide enough to hold the maximum length itself
  localparam int LEN_A_BITS   = 7;
  localparam int LEN_BC_BITS  = 4;

  // sum-of-pairs scoring, linear gaps
  localparam int MATCH_SCORE    = 2;
  localparam int MISMATCH_SCORE = -1;
  localparam int GAP_SCORE      = -2;

  // smallest signed score, start value of the max search
  localparam int SCORE_FLOOR = -(2 ** (SCORE_BITS - 1));

  // predecessor moves of one cell
  localparam int NUM_MOVES = 7;

  // fetch FSM encoding
  localparam int FSM_BITS = 2;
  localparam logic [FSM_BITS-1:0] ST_IDLE = 2'd0;
  localparam logic [FSM_BITS-1:0] ST_LOAD = 2'd1;
  localparam logic [FSM_BITS-1:0] ST_WALK = 2'd2;

endpackage
